// File: all.f
rtl/l1_cache_pkg.sv
rtl/generic_bus_if.sv
rtl/direct_mapped_cache.sv
rtl/mem_arbiter.sv
rtl/separate_caches.sv
dv/mem_model.sv
dv/tb_separate_caches.sv

// File: dv/mem_model.sv
//////////////////////////////////////////////////
// behavioral memory behind the cache memory port
// 256 words on the request/busy bus with 0 to 3
// random wait states per transfer
//////////////////////////////////////////////////

`default_nettype none

module mem_model (
    input  logic                   CLK,
    input  logic                   rst,
    input  logic                   mem_ren,
    input  logic                   mem_wen,
    input  l1_cache_pkg::word_t    mem_addr,
    input  l1_cache_pkg::word_t    mem_wdata,
    input  l1_cache_pkg::byte_en_t mem_byte_en,
    output l1_cache_pkg::word_t    mem_rdata,
    output logic                   mem_busy
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS = 256;

    l1_cache_pkg::word_t mem [MEM_WORDS];
    int                  seed;
    // wait states left before the current transfer completes
    logic [1:0]          wait_left;

    assign mem_rdata = mem[mem_addr[9:2]];
    assign mem_busy  = (mem_ren || mem_wen) && (wait_left != 2'd0);

    initial begin
        seed = 32'h0ee53169;
    end

    always @(posedge CLK) begin
        if (rst) begin
            // preload, pattern follows the word address
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= {8'(i), 8'(i) ^ 8'h3c, ~8'(i), 8'(i * 5)};
            end
            wait_left <= 2'($random(seed));
        end else if (mem_ren || mem_wen) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                // transfer completes here, draw the next wait count
                wait_left <= 2'($random(seed));
                for (int b = 0; b < 4; b++) begin
                    if (mem_wen && mem_byte_en[b]) begin
                        mem[mem_addr[9:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_separate_caches.sv
//////////////////////////////////////////////////
// testbench for the split l1 cache subsystem
// fetches, loads and stores against a shadow
// memory, clear timing and arbitration
//////////////////////////////////////////////////

`default_nettype none

module tb_separate_caches;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int MEM_WORDS      = 256;
    localparam int CLEAR_CYCLES   = 17;

    logic                   CLK;
    logic                   rst;
    logic                   iren;
    l1_cache_pkg::word_t    iaddr;
    l1_cache_pkg::word_t    irdata;
    logic                   ibusy;
    logic                   dren;
    logic                   dwen;
    l1_cache_pkg::word_t    daddr;
    l1_cache_pkg::word_t    dwdata;
    l1_cache_pkg::byte_en_t dbyte_en;
    l1_cache_pkg::word_t    drdata;
    logic                   dbusy;
    logic                   icache_clear;
    logic                   dcache_clear;
    logic                   iclear_done;
    logic                   dclear_done;
    logic                   icache_miss;
    logic                   dcache_miss;
    logic                   mem_ren;
    logic                   mem_wen;
    l1_cache_pkg::word_t    mem_addr;
    l1_cache_pkg::word_t    mem_wdata;
    l1_cache_pkg::byte_en_t mem_byte_en;
    l1_cache_pkg::word_t    mem_rdata;
    logic                   mem_busy;

    int                  seed;
    int                  mismatches;
    int                  timeouts;
    l1_cache_pkg::word_t shadow [MEM_WORDS];
    // expected line residency per side (0 icache, 1 dcache)
    logic                valid_bits [2][l1_cache_pkg::NUM_LINES];
    l1_cache_pkg::word_t line_addr  [2][l1_cache_pkg::NUM_LINES];

    separate_caches dut0 (.*);

    mem_model mem0 (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic l1_cache_pkg::word_t fill_word(input int i);
        return {8'(i), 8'(i) ^ 8'h3c, ~8'(i), 8'(i * 5)};
    endfunction

    function automatic l1_cache_pkg::word_t merge_bytes(input l1_cache_pkg::word_t old,
                                                        input l1_cache_pkg::word_t data,
                                                        input l1_cache_pkg::byte_en_t be);
        l1_cache_pkg::word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // expected word as memory holds it
    function automatic l1_cache_pkg::word_t ref_read(input l1_cache_pkg::word_t addr);
        return shadow[addr[9:2]];
    endfunction

    // word aligned address inside the 256 word memory
    function automatic l1_cache_pkg::word_t random_addr();
        l1_cache_pkg::word_t r;
        r = $random(seed);
        return {22'd0, r[9:2], 2'b00};
    endfunction

    task automatic check_word(input string name, input l1_cache_pkg::word_t exp,
                              input l1_cache_pkg::word_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic end_run();
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // drives one request on either processor bus 1 ns past the edge
    task automatic transfer(input bit dside, input bit write,
                            input l1_cache_pkg::word_t addr,
                            input l1_cache_pkg::word_t wdata,
                            input l1_cache_pkg::byte_en_t be,
                            input l1_cache_pkg::word_t exp);
        l1_cache_pkg::index_t idx;
        logic                 exp_miss;
        logic                 busy_now;
        int                   cycles;
        string                side;
        idx      = addr[5:2];
        exp_miss = !write && !(valid_bits[dside][idx] && line_addr[dside][idx] == addr);
        side     = dside ? "d" : "i";
        if (write) begin
            shadow[addr[9:2]] = merge_bytes(shadow[addr[9:2]], wdata, be);
        end
        if (dside) begin
            dren     = !write;
            dwen     = write;
            daddr    = addr;
            dwdata   = wdata;
            dbyte_en = be;
        end else begin
            iren  = 1'b1;
            iaddr = addr;
        end
        @(negedge CLK);
        busy_now = dside ? dbusy : ibusy;
        check_bit({side, "cache_miss"}, exp_miss, dside ? dcache_miss : icache_miss);
        check_bit({side, "busy"}, write || exp_miss, busy_now);
        cycles = 0;
        while (busy_now && cycles < TIMEOUT_CYCLES) begin
            @(negedge CLK);
            cycles++;
            busy_now = dside ? dbusy : ibusy;
            // miss flag is a single cycle pulse
            check_bit({side, "cache_miss"}, 1'b0, dside ? dcache_miss : icache_miss);
        end
        if (busy_now) begin
            timeouts++;
            $display("timeout: %sbusy still high after %0d cycles at %0t", side, cycles, $time);
            end_run();
        end else begin
            if (!write) begin
                check_word(dside ? "drdata" : "irdata", exp, dside ? drdata : irdata);
                valid_bits[dside][idx] = 1'b1;
                line_addr[dside][idx]  = addr;
            end
            @(posedge CLK);
            #1;
            if (dside) begin
                dren = 1'b0;
                dwen = 1'b0;
            end else begin
                iren = 1'b0;
            end
        end
    endtask

    task automatic run_clear(input bit dside);
        int    cycles;
        logic  done_now;
        string name;
        name = dside ? "dclear_done" : "iclear_done";
        if (dside) begin
            dcache_clear = 1'b1;
        end else begin
            icache_clear = 1'b1;
        end
        cycles   = 0;
        done_now = 1'b0;
        while (!done_now && cycles < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            #1;
            if (dside) begin
                dcache_clear = 1'b0;
            end else begin
                icache_clear = 1'b0;
            end
            @(negedge CLK);
            cycles++;
            done_now = dside ? dclear_done : iclear_done;
            check_bit(name, cycles == CLEAR_CYCLES, done_now);
        end
        if (!done_now) begin
            timeouts++;
            $display("timeout: %s never rose after the clear pulse", name);
            end_run();
        end else begin
            for (int i = 0; i < l1_cache_pkg::NUM_LINES; i++) begin
                valid_bits[dside][i] = 1'b0;
            end
            @(posedge CLK);
            #1;
        end
    endtask

    initial begin
        l1_cache_pkg::word_t a;
        l1_cache_pkg::word_t b;
        l1_cache_pkg::word_t stale;
        seed         = 32'h0ee53169;
        mismatches   = 0;
        timeouts     = 0;
        rst          = 1'b1;
        iren         = 1'b0;
        iaddr        = '0;
        dren         = 1'b0;
        dwen         = 1'b0;
        daddr        = '0;
        dwdata       = '0;
        dbyte_en     = '0;
        icache_clear = 1'b0;
        dcache_clear = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = fill_word(i);
        end
        for (int i = 0; i < l1_cache_pkg::NUM_LINES; i++) begin
            valid_bits[0][i] = 1'b0;
            valid_bits[1][i] = 1'b0;
        end
        repeat (16) @(posedge CLK);
        #1;
        rst = 1'b0;
        @(negedge CLK);
        check_bit("ibusy", 1'b0, ibusy);
        check_bit("dbusy", 1'b0, dbusy);
        check_bit("mem_ren", 1'b0, mem_ren);
        check_bit("mem_wen", 1'b0, mem_wen);
        check_bit("icache_miss", 1'b0, icache_miss);
        check_bit("dcache_miss", 1'b0, dcache_miss);
        check_bit("iclear_done", 1'b0, iclear_done);
        check_bit("dclear_done", 1'b0, dclear_done);
        @(posedge CLK);
        #1;

        // each fetch is followed by an immediate repeat that must hit
        repeat (12) begin
            a = random_addr();
            transfer(1'b0, 1'b0, a, '0, '0, ref_read(a));
            transfer(1'b0, 1'b0, a, '0, '0, ref_read(a));
        end

        // odd rounds load first so the store hits
        for (int n = 0; n < 12; n++) begin
            a = random_addr();
            if (n % 2 == 1) begin
                transfer(1'b1, 1'b0, a, '0, '0, ref_read(a));
            end
            transfer(1'b1, 1'b1, a, $random(seed), 4'($random(seed)), '0);
            transfer(1'b1, 1'b0, a, '0, '0, ref_read(a));
        end

        // same index with different tags
        run_clear(1'b1);
        a = random_addr();
        b = a ^ 32'h0000_0040;
        repeat (3) begin
            transfer(1'b1, 1'b0, a, '0, '0, ref_read(a));
            transfer(1'b1, 1'b0, b, '0, '0, ref_read(b));
        end

        fork
            run_clear(1'b0);
            run_clear(1'b1);
        join
        a = random_addr();
        transfer(1'b0, 1'b0, a, '0, '0, ref_read(a));
        transfer(1'b0, 1'b0, a, '0, '0, ref_read(a));
        run_clear(1'b0);
        transfer(1'b0, 1'b0, a, '0, '0, ref_read(a));
        // icache keeps the old word until it is cleared
        stale = ref_read(a);
        transfer(1'b1, 1'b1, a, ~stale, 4'hf, '0);
        transfer(1'b0, 1'b0, a, '0, '0, stale);
        run_clear(1'b0);
        transfer(1'b0, 1'b0, a, '0, '0, ref_read(a));

        // both caches miss in the same cycle
        fork
            run_clear(1'b0);
            run_clear(1'b1);
        join
        repeat (8) begin
            a = random_addr();
            b = random_addr();
            fork
                transfer(1'b0, 1'b0, a, '0, '0, ref_read(a));
                transfer(1'b1, 1'b0, b, '0, '0, ref_read(b));
            join
        end

        end_run();
    end

endmodule

`default_nettype wire

// File: rtl/direct_mapped_cache.sv
//////////////////////////////////////////////////
// direct mapped write-through cache
// 16 one-word lines, fill on read miss, stores go
// through to memory, no write allocate, clear
// walker invalidates one line per cycle
//////////////////////////////////////////////////

`default_nettype none

module direct_mapped_cache (
    input  logic               CLK,
    input  logic               rst,
    generic_bus_if.generic_bus proc_bus,
    generic_bus_if.cpu         mem_bus,
    input  logic               clear,
    output logic               clear_done,
    output logic               cache_miss
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_WRITE,
        ST_CLEAR
    } state_e;

    state_e state;
    state_e next_state;

    l1_cache_pkg::cache_line_t lines [l1_cache_pkg::NUM_LINES];
    l1_cache_pkg::cache_line_t cur_line;
    l1_cache_pkg::index_t      index;
    l1_cache_pkg::index_t      clear_idx;
    l1_cache_pkg::tag_t        tag;
    l1_cache_pkg::word_t       merged_data;

    logic hit;
    logic mem_done;
    logic last_idx;
    // set for the cycle after a fill or write-through completes
    logic xfer_done;

    assign index    = proc_bus.addr[l1_cache_pkg::INDEX_BITS+1:2];
    assign tag      = proc_bus.addr[31 -: l1_cache_pkg::TAG_BITS];
    assign cur_line = lines[index];
    assign hit      = cur_line.valid && (cur_line.tag == tag);
    assign mem_done = !mem_bus.busy;
    assign last_idx = (clear_idx == l1_cache_pkg::index_t'(l1_cache_pkg::NUM_LINES - 1));

    // hits and completed fills both read straight from the array
    assign proc_bus.rdata = cur_line.data;

    // processor holds the request stable, so forward it as is
    assign mem_bus.addr    = proc_bus.addr;
    assign mem_bus.wdata   = proc_bus.wdata;
    assign mem_bus.byte_en = proc_bus.byte_en;

    // store data merged into the cached word
    always_comb begin
        merged_data = cur_line.data;
        for (int b = 0; b < 4; b++) begin
            if (proc_bus.byte_en[b]) begin
                merged_data[8*b +: 8] = proc_bus.wdata[8*b +: 8];
            end
        end
    end

    always_comb begin
        next_state     = state;
        proc_bus.busy  = 1'b0;
        mem_bus.ren    = 1'b0;
        mem_bus.wen    = 1'b0;
        cache_miss     = 1'b0;
        case (state)
            ST_IDLE: begin
                if (clear) begin
                    next_state    = ST_CLEAR;
                    proc_bus.busy = proc_bus.ren | proc_bus.wen;
                end else if (xfer_done) begin
                    // completing cycle of a miss or store
                    proc_bus.busy = 1'b0;
                end else if (proc_bus.wen) begin
                    next_state    = ST_WRITE;
                    proc_bus.busy = 1'b1;
                end else if (proc_bus.ren && !hit) begin
                    // miss flag only for reads, stores always go out
                    next_state    = ST_FILL;
                    proc_bus.busy = 1'b1;
                    cache_miss    = 1'b1;
                end
            end
            ST_FILL: begin
                proc_bus.busy = 1'b1;
                mem_bus.ren   = 1'b1;
                if (mem_done) begin
                    next_state = ST_IDLE;
                end
            end
            ST_WRITE: begin
                proc_bus.busy = 1'b1;
                mem_bus.wen   = 1'b1;
                if (mem_done) begin
                    next_state = ST_IDLE;
                end
            end
            ST_CLEAR: begin
                proc_bus.busy = proc_bus.ren | proc_bus.wen;
                if (last_idx) begin
                    next_state = ST_IDLE;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state      <= ST_IDLE;
            clear_idx  <= '0;
            clear_done <= 1'b0;
            xfer_done  <= 1'b0;
        end else begin
            state      <= next_state;
            clear_done <= (state == ST_CLEAR) && last_idx;
            xfer_done  <= ((state == ST_FILL) || (state == ST_WRITE)) && mem_done;
            // walker index wraps back to zero after line 15
            if (state == ST_CLEAR) begin
                clear_idx <= clear_idx + 1'b1;
            end else begin
                clear_idx <= '0;
            end
        end
    end

    // line array, only the valid bits are reset
    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < l1_cache_pkg::NUM_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else begin
            case (state)
                ST_FILL: begin
                    if (mem_done) begin
                        lines[index] <= '{valid: 1'b1, tag: tag, data: mem_bus.rdata};
                    end
                end
                ST_WRITE: begin
                    if (mem_done && hit) begin
                        lines[index].data <= merged_data;
                    end
                end
                ST_CLEAR: lines[clear_idx].valid <= 1'b0;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/generic_bus_if.sv
//////////////////////////////////////////////////
// generic request/busy bus
// requester holds ren or wen with addr, wdata and
// byte_en until a cycle with busy low completes it
//////////////////////////////////////////////////

`default_nettype none

interface generic_bus_if;

    l1_cache_pkg::word_t    addr;
    l1_cache_pkg::word_t    wdata;
    l1_cache_pkg::byte_en_t byte_en;
    logic                   ren;
    logic                   wen;
    l1_cache_pkg::word_t    rdata;
    logic                   busy;

    // requester side
    modport cpu (
        output addr, wdata, byte_en, ren, wen,
        input  rdata, busy
    );

    // responder side
    modport generic_bus (
        input  addr, wdata, byte_en, ren, wen,
        output rdata, busy
    );

endinterface

`default_nettype wire

// File: rtl/l1_cache_pkg.sv
//////////////////////////////////////////////////
// l1 cache package
// word, index and tag types plus the cache line
// layout shared by the split instruction and data
// caches
//////////////////////////////////////////////////

`default_nettype none

package l1_cache_pkg;

    // data and address word
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;

    // direct mapped, one word per line
    localparam int NUM_LINES  = 16;
    localparam int INDEX_BITS = 4;
    localparam int TAG_BITS   = 26;

    // index is addr[5:2], tag is addr[31:6]
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } cache_line_t;

endpackage

`default_nettype wire

// File: rtl/mem_arbiter.sv
//////////////////////////////////////////////////
// memory arbiter
// shares one memory port between the data cache
// and the instruction cache, data cache first
//////////////////////////////////////////////////

`default_nettype none

module mem_arbiter (
    input  logic               CLK,
    input  logic               rst,
    generic_bus_if.generic_bus icache_bus,
    generic_bus_if.generic_bus dcache_bus,
    generic_bus_if.cpu         mem_bus
);

    typedef enum logic {
        OWN_DCACHE,
        OWN_ICACHE
    } owner_e;

    owner_e owner;
    owner_e grant;
    // owner is locked while its transfer is stalled
    logic   held;
    logic   mem_req;

    always_comb begin
        if (held) begin
            grant = owner;
        end else if (dcache_bus.ren || dcache_bus.wen) begin
            grant = OWN_DCACHE;
        end else if (icache_bus.ren || icache_bus.wen) begin
            grant = OWN_ICACHE;
        end else begin
            grant = OWN_DCACHE;
        end
    end

    // forward the granted request with no added cycle
    always_comb begin
        if (grant == OWN_DCACHE) begin
            mem_bus.addr    = dcache_bus.addr;
            mem_bus.wdata   = dcache_bus.wdata;
            mem_bus.byte_en = dcache_bus.byte_en;
            mem_bus.ren     = dcache_bus.ren;
            mem_bus.wen     = dcache_bus.wen;
        end else begin
            mem_bus.addr    = icache_bus.addr;
            mem_bus.wdata   = icache_bus.wdata;
            mem_bus.byte_en = icache_bus.byte_en;
            mem_bus.ren     = icache_bus.ren;
            mem_bus.wen     = icache_bus.wen;
        end
    end

    assign mem_req = mem_bus.ren | mem_bus.wen;

    // the cache without the grant just waits
    assign dcache_bus.rdata = mem_bus.rdata;
    assign icache_bus.rdata = mem_bus.rdata;
    assign dcache_bus.busy  = (grant == OWN_DCACHE) ? mem_bus.busy : 1'b1;
    assign icache_bus.busy  = (grant == OWN_ICACHE) ? mem_bus.busy : 1'b1;

    // released in the cycle memory drops busy
    always_ff @(posedge CLK) begin
        if (rst) begin
            owner <= OWN_DCACHE;
            held  <= 1'b0;
        end else begin
            owner <= grant;
            held  <= mem_req && mem_bus.busy;
        end
    end

endmodule

`default_nettype wire

// File: rtl/separate_caches.sv
//////////////////////////////////////////////////
// split l1 cache subsystem
// instruction cache and data cache sharing one
// memory port through the arbiter
//////////////////////////////////////////////////

`default_nettype none

module separate_caches (
    input  logic                   CLK,
    input  logic                   rst,
    // instruction side
    input  logic                   iren,
    input  l1_cache_pkg::word_t    iaddr,
    output l1_cache_pkg::word_t    irdata,
    output logic                   ibusy,
    // data side
    input  logic                   dren,
    input  logic                   dwen,
    input  l1_cache_pkg::word_t    daddr,
    input  l1_cache_pkg::word_t    dwdata,
    input  l1_cache_pkg::byte_en_t dbyte_en,
    output l1_cache_pkg::word_t    drdata,
    output logic                   dbusy,
    // clear control
    input  logic                   icache_clear,
    input  logic                   dcache_clear,
    output logic                   iclear_done,
    output logic                   dclear_done,
    output logic                   icache_miss,
    output logic                   dcache_miss,
    // memory port
    output logic                   mem_ren,
    output logic                   mem_wen,
    output l1_cache_pkg::word_t    mem_addr,
    output l1_cache_pkg::word_t    mem_wdata,
    output l1_cache_pkg::byte_en_t mem_byte_en,
    input  l1_cache_pkg::word_t    mem_rdata,
    input  logic                   mem_busy
);

    generic_bus_if icache_proc_bus ();
    generic_bus_if dcache_proc_bus ();
    generic_bus_if icache_mem_bus ();
    generic_bus_if dcache_mem_bus ();
    generic_bus_if mem_bus ();

    // fetch side never writes
    assign icache_proc_bus.ren     = iren;
    assign icache_proc_bus.wen     = 1'b0;
    assign icache_proc_bus.addr    = iaddr;
    assign icache_proc_bus.wdata   = '0;
    assign icache_proc_bus.byte_en = '1;
    assign irdata                  = icache_proc_bus.rdata;
    assign ibusy                   = icache_proc_bus.busy;

    assign dcache_proc_bus.ren     = dren;
    assign dcache_proc_bus.wen     = dwen;
    assign dcache_proc_bus.addr    = daddr;
    assign dcache_proc_bus.wdata   = dwdata;
    assign dcache_proc_bus.byte_en = dbyte_en;
    assign drdata                  = dcache_proc_bus.rdata;
    assign dbusy                   = dcache_proc_bus.busy;

    assign mem_ren       = mem_bus.ren;
    assign mem_wen       = mem_bus.wen;
    assign mem_addr      = mem_bus.addr;
    assign mem_wdata     = mem_bus.wdata;
    assign mem_byte_en   = mem_bus.byte_en;
    assign mem_bus.rdata = mem_rdata;
    assign mem_bus.busy  = mem_busy;

    direct_mapped_cache icache (
        .CLK        (CLK),
        .rst        (rst),
        .proc_bus   (icache_proc_bus),
        .mem_bus    (icache_mem_bus),
        .clear      (icache_clear),
        .clear_done (iclear_done),
        .cache_miss (icache_miss)
    );

    direct_mapped_cache dcache (
        .CLK        (CLK),
        .rst        (rst),
        .proc_bus   (dcache_proc_bus),
        .mem_bus    (dcache_mem_bus),
        .clear      (dcache_clear),
        .clear_done (dclear_done),
        .cache_miss (dcache_miss)
    );

    mem_arbiter arb (
        .CLK        (CLK),
        .rst        (rst),
        .icache_bus (icache_mem_bus),
        .dcache_bus (dcache_mem_bus),
        .mem_bus    (mem_bus)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the split cache testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f \
    --top-module tb_separate_caches -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "pass message not found"
exit 1
